// File: rtl/mipsPkg.sv
package mipsPkg;

    ////////////////////////////////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////////////////////////////////

    // Primary opcodes, instruction bits 31:26
    localparam logic [5:0] OpRType = 6'h00;
    localparam logic [5:0] OpJ     = 6'h02;
    localparam logic [5:0] OpBeq   = 6'h04;
    localparam logic [5:0] OpBne   = 6'h05;
    localparam logic [5:0] OpAddi  = 6'h08;
    localparam logic [5:0] OpLw    = 6'h23;
    localparam logic [5:0] OpSw    = 6'h2b;

    // R-type function codes, bits 5:0
    localparam logic [5:0] FunctAdd = 6'h20;
    localparam logic [5:0] FunctSub = 6'h22;
    localparam logic [5:0] FunctAnd = 6'h24;
    localparam logic [5:0] FunctOr  = 6'h25;
    localparam logic [5:0] FunctSlt = 6'h2a;

    // Operation handed from decode to the ALU
    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluSlt
    } aluOpT;

    ////////////////////////////////////////////////////////////////////
    // Memories and registers
    ////////////////////////////////////////////////////////////////////

    // Word-addressed instruction and data memories
    localparam int ImemDepth    = 256;
    localparam int DmemDepth    = 256;
    localparam int ImemAddrBits = $clog2(ImemDepth);
    localparam int DmemAddrBits = $clog2(DmemDepth);

    // Hardwired zero register
    localparam logic [4:0] RegZero = 5'd0;

endpackage

// File: rtl/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic        Clk,
    input  logic        rst,
    input  logic [4:0]  RsAddr,
    input  logic [4:0]  RtAddr,
    input  logic        WeW,
    input  logic [4:0]  WAddr,
    input  logic [31:0] WData,
    output logic [31:0] RsData,
    output logic [31:0] RtData
);
    import mipsPkg::*;

    logic [31:0] regs [32];

    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (WeW && WAddr != RegZero) begin
            regs[WAddr] <= WData;
        end
    end

    // Same-cycle write is seen by the reader
    assign RsData = (RsAddr == RegZero)      ? 32'd0 :
                    (WeW && WAddr == RsAddr) ? WData : regs[RsAddr];
    assign RtData = (RtAddr == RegZero)      ? 32'd0 :
                    (WeW && WAddr == RtAddr) ? WData : regs[RtAddr];

endmodule

// File: rtl/fetchStage.sv
`timescale 1ns/1ps

module fetchStage (
    input  logic                             Clk,
    input  logic                             rst,
    input  logic                             ImemWe,
    input  logic [mipsPkg::ImemAddrBits-1:0] ImemAddr,
    input  logic [31:0]                      ImemData,
    input  logic                             Stall,
    input  logic                             Redirect,
    input  logic [31:0]                      RedirectPc,
    output logic [31:0]                      InstrD,
    output logic [31:0]                      PcPlus4D
);
    import mipsPkg::*;

    logic [31:0] pc;
    logic [31:0] pcPlus4;
    logic [31:0] nextPc;
    logic [31:0] instrF;
    logic [31:0] imem [ImemDepth];

    // Program load port
    always_ff @(posedge Clk) begin
        if (ImemWe) begin
            imem[ImemAddr] <= ImemData;
        end
    end

    assign instrF  = imem[pc[ImemAddrBits+1:2]];
    assign pcPlus4 = pc + 32'd4;

    // Redirect and Stall never arrive together
    always_comb begin
        if (Redirect) begin
            nextPc = RedirectPc;
        end else if (Stall) begin
            nextPc = pc;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            pc <= 32'd0;
        end else begin
            pc <= nextPc;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Fetch/decode register
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (rst || Redirect) begin
            // All-zero word decodes as a nop
            InstrD   <= 32'd0;
            PcPlus4D <= 32'd0;
        end else if (!Stall) begin
            InstrD   <= instrF;
            PcPlus4D <= pcPlus4;
        end
    end

endmodule

// File: rtl/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input  logic                Clk,
    input  logic                rst,
    input  logic [31:0]         InstrD,
    input  logic [31:0]         PcPlus4D,
    input  logic [31:0]         RsData,
    input  logic [31:0]         RtData,
    input  logic                RegWriteE,
    input  logic [4:0]          DstE,
    input  logic                RegWriteM,
    input  logic [4:0]          DstM,
    output logic [4:0]          RsAddr,
    output logic [4:0]          RtAddr,
    output logic                Stall,
    output logic                Redirect,
    output logic [31:0]         RedirectPc,
    output logic                RegWriteE_q,
    output logic                MemWriteE,
    output logic                MemToRegE,
    output logic                AluSrcE,
    output mipsPkg::aluOpT      AluOpE,
    output logic [31:0]         RsValE,
    output logic [31:0]         RtValE,
    output logic [31:0]         ImmE,
    output logic [4:0]          DstE_q
);
    import mipsPkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [31:0] immExt;

    logic   regWriteD;
    logic   memWriteD;
    logic   memToRegD;
    logic   aluSrcD;
    logic   regDstD;
    logic   branchEqD;
    logic   branchNeD;
    logic   jumpD;
    logic   usesRs;
    logic   usesRt;
    aluOpT  aluOpD;
    logic [4:0] dstD;

    logic takenD;
    logic rsHazard;
    logic rtHazard;

    assign opcode = InstrD[31:26];
    assign rs     = InstrD[25:21];
    assign rt     = InstrD[20:16];
    assign rd     = InstrD[15:11];
    assign funct  = InstrD[5:0];
    assign immExt = {{16{InstrD[15]}}, InstrD[15:0]};
    assign RsAddr = rs;
    assign RtAddr = rt;

    ////////////////////////////////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        regWriteD = 1'b0;
        memWriteD = 1'b0;
        memToRegD = 1'b0;
        aluSrcD   = 1'b0;
        regDstD   = 1'b0;
        branchEqD = 1'b0;
        branchNeD = 1'b0;
        jumpD     = 1'b0;
        usesRs    = 1'b0;
        usesRt    = 1'b0;
        aluOpD    = AluAdd;
        case (opcode)
            OpRType: begin
                regDstD = 1'b1;
                usesRs  = 1'b1;
                usesRt  = 1'b1;
                // Unsupported funct codes do not write
                regWriteD = 1'b1;
                case (funct)
                    FunctAdd: aluOpD = AluAdd;
                    FunctSub: aluOpD = AluSub;
                    FunctAnd: aluOpD = AluAnd;
                    FunctOr:  aluOpD = AluOr;
                    FunctSlt: aluOpD = AluSlt;
                    default:  regWriteD = 1'b0;
                endcase
            end
            OpAddi: begin
                regWriteD = 1'b1;
                aluSrcD   = 1'b1;
                usesRs    = 1'b1;
            end
            OpLw: begin
                regWriteD = 1'b1;
                memToRegD = 1'b1;
                aluSrcD   = 1'b1;
                usesRs    = 1'b1;
            end
            OpSw: begin
                memWriteD = 1'b1;
                aluSrcD   = 1'b1;
                usesRs    = 1'b1;
                usesRt    = 1'b1;
            end
            OpBeq: begin
                branchEqD = 1'b1;
                usesRs    = 1'b1;
                usesRt    = 1'b1;
            end
            OpBne: begin
                branchNeD = 1'b1;
                usesRs    = 1'b1;
                usesRt    = 1'b1;
            end
            OpJ:     jumpD = 1'b1;
            default: ;
        endcase
    end

    assign dstD = regDstD ? rd : rt;

    // Branches resolve here without a delay slot
    assign takenD = (branchEqD && RsData == RtData) ||
                    (branchNeD && RsData != RtData);

    assign RedirectPc = jumpD ? {PcPlus4D[31:28], InstrD[25:0], 2'b00}
                              : PcPlus4D + {immExt[29:0], 2'b00};

    // Producers still in execute or memory
    assign rsHazard = usesRs && rs != RegZero &&
                      ((RegWriteE && DstE == rs) || (RegWriteM && DstM == rs));
    assign rtHazard = usesRt && rt != RegZero &&
                      ((RegWriteE && DstE == rt) || (RegWriteM && DstM == rt));

    assign Stall    = rsHazard || rtHazard;
    assign Redirect = !Stall && (takenD || jumpD);

    ////////////////////////////////////////////////////////////////////
    // Decode/execute register
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (rst || Stall) begin
            // Bubble
            RegWriteE_q <= 1'b0;
            MemWriteE   <= 1'b0;
            MemToRegE   <= 1'b0;
        end else begin
            RegWriteE_q <= regWriteD && dstD != RegZero;
            MemWriteE   <= memWriteD;
            MemToRegE   <= memToRegD;
        end
    end

    always_ff @(posedge Clk) begin
        AluSrcE <= aluSrcD;
        AluOpE  <= aluOpD;
        RsValE  <= RsData;
        RtValE  <= RtData;
        ImmE    <= immExt;
        DstE_q  <= dstD;
    end

endmodule

// File: rtl/executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input  logic           Clk,
    input  logic           rst,
    input  logic           RegWriteE,
    input  logic           MemWriteE,
    input  logic           MemToRegE,
    input  logic           AluSrcE,
    input  mipsPkg::aluOpT AluOpE,
    input  logic [31:0]    RsValE,
    input  logic [31:0]    RtValE,
    input  logic [31:0]    ImmE,
    input  logic [4:0]     DstE,
    output logic           RegWriteM,
    output logic           MemWriteM,
    output logic           MemToRegM,
    output logic [31:0]    AluResM,
    output logic [31:0]    StoreDataM,
    output logic [4:0]     DstM
);
    import mipsPkg::*;

    logic [31:0] srcB;
    logic [31:0] aluRes;

    assign srcB = AluSrcE ? ImmE : RtValE;

    always_comb begin
        case (AluOpE)
            AluSub:  aluRes = RsValE - srcB;
            AluAnd:  aluRes = RsValE & srcB;
            AluOr:   aluRes = RsValE | srcB;
            // Signed compare
            AluSlt:  aluRes = {31'd0, $signed(RsValE) < $signed(srcB)};
            default: aluRes = RsValE + srcB;
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // Execute/memory register
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (rst) begin
            RegWriteM <= 1'b0;
            MemWriteM <= 1'b0;
        end else begin
            RegWriteM <= RegWriteE;
            MemWriteM <= MemWriteE;
        end
    end

    always_ff @(posedge Clk) begin
        MemToRegM  <= MemToRegE;
        AluResM    <= aluRes;
        StoreDataM <= RtValE;
        DstM       <= DstE;
    end

endmodule

// File: rtl/memoryStage.sv
`timescale 1ns/1ps

module memoryStage (
    input  logic        Clk,
    input  logic        rst,
    input  logic        RegWriteM,
    input  logic        MemWriteM,
    input  logic        MemToRegM,
    input  logic [31:0] AluResM,
    input  logic [31:0] StoreDataM,
    input  logic [4:0]  DstM,
    output logic        WbValid,
    output logic [4:0]  WbReg,
    output logic [31:0] WbData
);
    import mipsPkg::*;

    logic [31:0]             dmem [DmemDepth];
    logic [DmemAddrBits-1:0] dAddr;
    logic [31:0]             loadData;

    // Word address from the byte address
    assign dAddr    = AluResM[DmemAddrBits+1:2];
    assign loadData = dmem[dAddr];

    always_ff @(posedge Clk) begin
        if (MemWriteM) begin
            dmem[dAddr] <= StoreDataM;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Memory/writeback register
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (rst) begin
            WbValid <= 1'b0;
        end else begin
            WbValid <= RegWriteM;
        end
    end

    always_ff @(posedge Clk) begin
        WbReg  <= DstM;
        WbData <= MemToRegM ? loadData : AluResM;
    end

endmodule

// File: rtl/mipsPipeline.sv
`timescale 1ns/1ps

module mipsPipeline (
    input  logic                             Clk,
    input  logic                             rst,
    input  logic                             ImemWe,
    input  logic [mipsPkg::ImemAddrBits-1:0] ImemAddr,
    input  logic [31:0]                      ImemData,
    output logic                             WbValid,
    output logic [4:0]                       WbReg,
    output logic [31:0]                      WbData
);
    import mipsPkg::*;

    logic [31:0] instrD;
    logic [31:0] pcPlus4D;
    logic        stall;
    logic        redirect;
    logic [31:0] redirectPc;
    logic [4:0]  rsAddr;
    logic [4:0]  rtAddr;
    logic [31:0] rsData;
    logic [31:0] rtData;

    // Execute bundle
    logic        regWriteE;
    logic        memWriteE;
    logic        memToRegE;
    logic        aluSrcE;
    aluOpT       aluOpE;
    logic [31:0] rsValE;
    logic [31:0] rtValE;
    logic [31:0] immE;
    logic [4:0]  dstE;

    // Memory bundle
    logic        regWriteM;
    logic        memWriteM;
    logic        memToRegM;
    logic [31:0] aluResM;
    logic [31:0] storeDataM;
    logic [4:0]  dstM;

    fetchStage fetchStage_inst (
        .Clk(Clk), .rst(rst),
        .ImemWe(ImemWe), .ImemAddr(ImemAddr), .ImemData(ImemData),
        .Stall(stall), .Redirect(redirect), .RedirectPc(redirectPc),
        .InstrD(instrD), .PcPlus4D(pcPlus4D)
    );

    regFile regFile_inst (
        .Clk(Clk), .rst(rst),
        .RsAddr(rsAddr), .RtAddr(rtAddr),
        .WeW(WbValid), .WAddr(WbReg), .WData(WbData),
        .RsData(rsData), .RtData(rtData)
    );

    decodeStage decodeStage_inst (
        .Clk(Clk), .rst(rst),
        .InstrD(instrD), .PcPlus4D(pcPlus4D),
        .RsData(rsData), .RtData(rtData),
        .RegWriteE(regWriteE), .DstE(dstE),
        .RegWriteM(regWriteM), .DstM(dstM),
        .RsAddr(rsAddr), .RtAddr(rtAddr),
        .Stall(stall), .Redirect(redirect), .RedirectPc(redirectPc),
        .RegWriteE_q(regWriteE), .MemWriteE(memWriteE), .MemToRegE(memToRegE),
        .AluSrcE(aluSrcE), .AluOpE(aluOpE),
        .RsValE(rsValE), .RtValE(rtValE), .ImmE(immE), .DstE_q(dstE)
    );

    executeStage executeStage_inst (
        .Clk(Clk), .rst(rst),
        .RegWriteE(regWriteE), .MemWriteE(memWriteE), .MemToRegE(memToRegE),
        .AluSrcE(aluSrcE), .AluOpE(aluOpE),
        .RsValE(rsValE), .RtValE(rtValE), .ImmE(immE), .DstE(dstE),
        .RegWriteM(regWriteM), .MemWriteM(memWriteM), .MemToRegM(memToRegM),
        .AluResM(aluResM), .StoreDataM(storeDataM), .DstM(dstM)
    );

    memoryStage memoryStage_inst (
        .Clk(Clk), .rst(rst),
        .RegWriteM(regWriteM), .MemWriteM(memWriteM), .MemToRegM(memToRegM),
        .AluResM(aluResM), .StoreDataM(storeDataM), .DstM(dstM),
        .WbValid(WbValid), .WbReg(WbReg), .WbData(WbData)
    );

endmodule

// File: test/mipsPipelineTb.sv
`timescale 1ns/1ps

module mipsPipelineTb;
    import mipsPkg::*;

    // Program region, large enough for every test
    localparam int LoadWords   = 64;
    localparam int RunLimit    = 150;
    localparam int DrainCycles = 40;
    localparam int CycleLimit  = 1500;

    logic                    Clk;
    logic                    rst;
    logic                    ImemWe;
    logic [ImemAddrBits-1:0] ImemAddr;
    logic [31:0]             ImemData;
    logic                    WbValid;
    logic [4:0]              WbReg;
    logic [31:0]             WbData;

    logic [31:0] progQ[$];
    logic [4:0]  expRegQ[$];
    logic [31:0] expDataQ[$];
    logic [4:0]  gotRegQ[$];
    logic [31:0] gotDataQ[$];

    int cycleCount;
    int testErrors;
    int passCount;
    int failCount;

    mipsPipeline mipsPipeline_inst (
        .Clk(Clk), .rst(rst),
        .ImemWe(ImemWe), .ImemAddr(ImemAddr), .ImemData(ImemData),
        .WbValid(WbValid), .WbReg(WbReg), .WbData(WbData)
    );

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    // Watchdog over the whole run
    initial begin
        cycleCount = 0;
        while (cycleCount < CycleLimit) begin
            @(posedge Clk);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", CycleLimit);
        $display("Simulation failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Instruction encoding
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] encodeR(input logic [5:0] funct, input int rd,
                                            input int rs, input int rt);
        return {OpRType, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input int rs,
                                            input int rt, input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [31:0] encodeJ(input int index);
        return {OpJ, 26'(index)};
    endfunction

    // Ends a program, loops on its own word
    function automatic logic [31:0] jumpToSelf();
        return encodeJ(progQ.size());
    endfunction

    function automatic logic [31:0] signExt(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    task automatic emit(input logic [31:0] word);
        progQ.push_back(word);
    endtask

    task automatic expectWrite(input int regNum, input logic [31:0] value);
        expRegQ.push_back(5'(regNum));
        expDataQ.push_back(value);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Run and compare
    //////////////////////////////////////////////////////////////////////

    task automatic stepCycle();
        @(posedge Clk);
        #1;
    endtask

    task automatic captureWriteback();
        if (WbValid) begin
            gotRegQ.push_back(WbReg);
            gotDataQ.push_back(WbData);
        end
    endtask

    task automatic runProgram(input string name);
        int waited;
        int n;
        testErrors = 0;
        gotRegQ.delete();
        gotDataQ.delete();
        rst = 1'b1;
        // Load while the pipeline sits in reset
        for (int a = 0; a < LoadWords; a++) begin
            ImemWe   = 1'b1;
            ImemAddr = a[ImemAddrBits-1:0];
            ImemData = (a < progQ.size()) ? progQ[a] : 32'd0;
            stepCycle();
        end
        ImemWe = 1'b0;
        repeat (2) stepCycle();
        rst = 1'b0;

        waited = 0;
        while (gotRegQ.size() < expRegQ.size() && waited < RunLimit) begin
            stepCycle();
            waited++;
            captureWriteback();
        end
        // Anything seen here is an extra write
        repeat (DrainCycles) begin
            stepCycle();
            captureWriteback();
        end

        assert (gotRegQ.size() >= expRegQ.size()) else begin
            $display("%s: %0d expected writebacks never happened", name,
                     expRegQ.size() - gotRegQ.size());
            testErrors++;
        end
        assert (gotRegQ.size() <= expRegQ.size()) else begin
            $display("%s: %0d extra writebacks after the last expected one", name,
                     gotRegQ.size() - expRegQ.size());
            testErrors++;
        end
        n = (gotRegQ.size() < expRegQ.size()) ? gotRegQ.size() : expRegQ.size();
        for (int i = 0; i < n; i++) begin
            assert (gotRegQ[i] == expRegQ[i]) else begin
                $display("Error: WbReg at writeback %0d expected 0x%02h got 0x%02h",
                         i, expRegQ[i], gotRegQ[i]);
                testErrors++;
            end
            assert (gotDataQ[i] == expDataQ[i]) else begin
                $display("Error: WbData at writeback %0d expected 0x%08h got 0x%08h",
                         i, expDataQ[i], gotDataQ[i]);
                testErrors++;
            end
        end

        if (testErrors == 0) begin
            passCount++;
            $display("%s: ok, %0d writebacks", name, gotRegQ.size());
        end else begin
            failCount++;
            $display("%s: FAILED with %0d errors", name, testErrors);
        end
        progQ.delete();
        expRegQ.delete();
        expDataQ.delete();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic aluIndependentOps();
        logic [15:0] immA;
        logic [15:0] immB;
        logic [31:0] a;
        logic [31:0] b;
        immA = 16'($urandom());
        immB = 16'($urandom());
        a = signExt(immA);
        b = signExt(immB);
        emit(encodeI(OpAddi, 0, 1, immA));
        emit(encodeI(OpAddi, 0, 2, immB));
        emit(encodeI(OpAddi, 0, 10, 7));
        emit(encodeI(OpAddi, 0, 11, 9));
        emit(encodeR(FunctAdd, 3, 1, 2));
        emit(encodeI(OpAddi, 0, 12, 11));
        emit(encodeR(FunctSub, 4, 1, 2));
        emit(encodeI(OpAddi, 10, 13, 1));
        emit(encodeR(FunctAnd, 5, 1, 2));
        emit(encodeR(FunctOr, 6, 1, 2));
        emit(encodeR(FunctSlt, 7, 1, 2));
        emit(encodeR(FunctSlt, 8, 2, 1));
        emit(jumpToSelf());
        expectWrite(1, a);
        expectWrite(2, b);
        expectWrite(10, 32'd7);
        expectWrite(11, 32'd9);
        expectWrite(3, a + b);
        expectWrite(12, 32'd11);
        expectWrite(4, a - b);
        expectWrite(13, 32'd8);
        expectWrite(5, a & b);
        expectWrite(6, a | b);
        expectWrite(7, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        expectWrite(8, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        runProgram("ALU independent ops");
    endtask

    task automatic dependencyChain();
        logic [15:0] immA;
        logic [15:0] immB;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        logic [31:0] r4;
        logic [31:0] r5;
        logic [31:0] r6;
        immA = 16'($urandom());
        immB = 16'($urandom());
        r1 = signExt(immA);
        emit(encodeI(OpAddi, 0, 1, immA));
        expectWrite(1, r1);
        r1 = r1 + signExt(immB);
        emit(encodeI(OpAddi, 1, 1, immB));
        expectWrite(1, r1);
        r2 = r1 + r1;
        r3 = r2 - r1;
        r4 = r3 | r2;
        r5 = r4 & r3;
        r6 = ($signed(r5) < $signed(r4)) ? 32'd1 : 32'd0;
        emit(encodeR(FunctAdd, 2, 1, 1));
        emit(encodeR(FunctSub, 3, 2, 1));
        emit(encodeR(FunctOr, 4, 3, 2));
        emit(encodeR(FunctAnd, 5, 4, 3));
        emit(encodeR(FunctSlt, 6, 5, 4));
        emit(encodeI(OpAddi, 6, 7, 5));
        emit(jumpToSelf());
        expectWrite(2, r2);
        expectWrite(3, r3);
        expectWrite(4, r4);
        expectWrite(5, r5);
        expectWrite(6, r6);
        expectWrite(7, r6 + 32'd5);
        runProgram("Dependency chain");
    endtask

    task automatic loadStoreAccess();
        logic [15:0] immA;
        logic [15:0] immB;
        logic [15:0] immC;
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] v3;
        immA = 16'($urandom());
        immB = 16'($urandom());
        immC = 16'($urandom());
        v1 = signExt(immA);
        v2 = signExt(immB);
        v3 = signExt(immC);
        emit(encodeI(OpAddi, 0, 1, immA));
        emit(encodeI(OpAddi, 0, 2, immB));
        emit(encodeI(OpAddi, 0, 3, immC));
        // Base address in r9
        emit(encodeI(OpAddi, 0, 9, 16'h0040));
        emit(encodeI(OpSw, 9, 1, 0));
        emit(encodeI(OpSw, 9, 2, 4));
        emit(encodeI(OpSw, 9, 3, 8));
        emit(encodeI(OpLw, 9, 4, 0));
        emit(encodeI(OpLw, 9, 5, 4));
        emit(encodeI(OpLw, 9, 6, 8));
        // Load-use right away
        emit(encodeR(FunctAdd, 7, 6, 5));
        emit(encodeI(OpLw, 9, 8, 4));
        emit(encodeR(FunctAdd, 10, 8, 4));
        emit(jumpToSelf());
        expectWrite(1, v1);
        expectWrite(2, v2);
        expectWrite(3, v3);
        expectWrite(9, 32'h40);
        expectWrite(4, v1);
        expectWrite(5, v2);
        expectWrite(6, v3);
        expectWrite(7, v3 + v2);
        expectWrite(8, v2);
        expectWrite(10, v2 + v1);
        runProgram("Load and store");
    endtask

    task automatic branchAndJump();
        emit(encodeI(OpAddi, 0, 1, 5));
        emit(encodeI(OpAddi, 0, 2, 5));
        emit(encodeI(OpAddi, 0, 3, 9));
        // Word 3, beq taken to word 5
        emit(encodeI(OpBeq, 1, 2, 1));
        emit(encodeI(OpAddi, 0, 20, 1));
        // Word 5, bne falls through
        emit(encodeI(OpBne, 1, 2, 1));
        emit(encodeI(OpAddi, 0, 4, 16'h44));
        // Word 7, bne taken to word 9
        emit(encodeI(OpBne, 1, 3, 1));
        emit(encodeI(OpAddi, 0, 21, 2));
        emit(encodeJ(11));
        emit(encodeI(OpAddi, 0, 22, 3));
        emit(encodeI(OpAddi, 0, 5, 16'h55));
        emit(encodeI(OpAddi, 0, 6, 9));
        // Word 13 needs r6 from the addi just before
        emit(encodeI(OpBeq, 6, 3, 1));
        emit(encodeI(OpAddi, 0, 23, 4));
        emit(encodeI(OpAddi, 6, 7, 1));
        emit(jumpToSelf());
        expectWrite(1, 32'd5);
        expectWrite(2, 32'd5);
        expectWrite(3, 32'd9);
        expectWrite(4, 32'h44);
        expectWrite(5, 32'h55);
        expectWrite(6, 32'd9);
        expectWrite(7, 32'd10);
        runProgram("Branch and jump");
    endtask

    task automatic zeroRegister();
        logic [15:0] immA;
        logic [31:0] a;
        immA = 16'($urandom());
        a = signExt(immA);
        emit(encodeI(OpAddi, 0, 1, immA));
        // Writes to r0 are dropped
        emit(encodeI(OpAddi, 0, 0, 16'h77));
        emit(encodeR(FunctAdd, 0, 1, 1));
        emit(encodeR(FunctAdd, 2, 0, 1));
        emit(encodeR(FunctAdd, 3, 1, 0));
        emit(jumpToSelf());
        expectWrite(1, a);
        expectWrite(2, a);
        expectWrite(3, a);
        runProgram("Register zero");
    endtask

    initial begin
        rst        = 1'b1;
        ImemWe     = 1'b0;
        ImemAddr   = '0;
        ImemData   = 32'd0;
        passCount  = 0;
        failCount  = 0;
        testErrors = 0;
        void'($urandom(32'h62f6378f));

        aluIndependentOps();
        dependencyChain();
        loadStoreAccess();
        branchAndJump();
        zeroRegister();

        $display("Tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: flist.f
rtl/mipsPkg.sv
rtl/regFile.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/mipsPipeline.sv
test/mipsPipelineTb.sv

// File: Bender.yml
package:
  name: mips_pipeline

sources:
  - files:
      - rtl/mipsPkg.sv
      - rtl/regFile.sv
      - rtl/fetchStage.sv
      - rtl/decodeStage.sv
      - rtl/executeStage.sv
      - rtl/memoryStage.sv
      - rtl/mipsPipeline.sv
  - target: test
    files:
      - test/mipsPipelineTb.sv
